//--- common/mem_core_pkg.sv
`default_nettype none

package mem_core_pkg;

  // geometry of the virtual memory and its replicated banks
  localparam int DATA_WIDTH   = 32;
  localparam int NUM_RD_PORTS = 2;
  localparam int NUM_BANKS    = 6;
  localparam int NUM_ROWS     = 64;
  localparam int NUM_ADDR     = NUM_BANKS * NUM_ROWS;
  localparam int ADDR_WIDTH   = 9;
  localparam int BANK_WIDTH   = 3;
  localparam int ROW_WIDTH    = 6;
  localparam int PADR_WIDTH   = BANK_WIDTH + ROW_WIDTH;

  // one copy of every bank per read port at index bank * NUM_RD_PORTS + port
  localparam int NUM_PHYS = NUM_BANKS * NUM_RD_PORTS;

  typedef struct packed {
    logic [BANK_WIDTH-1:0] bank;
    logic [ROW_WIDTH-1:0]  row;
  } bank_loc_t;

  typedef struct packed {
    logic                  vld;
    bank_loc_t             loc;
    logic [DATA_WIDTH-1:0] data;
  } wr_req_t;

  typedef struct packed {
    logic      vld;
    bank_loc_t loc;
  } rd_req_t;

  // request and response of one physical 1r1w SRAM
  typedef struct packed {
    logic                  en;
    logic [ROW_WIDTH-1:0]  row;
    logic [DATA_WIDTH-1:0] data;
  } phys_wr_t;

  typedef struct packed {
    logic                 en;
    logic [ROW_WIDTH-1:0] row;
  } phys_rd_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  fwrd;
    logic                  serr;
    logic                  derr;
    logic [ROW_WIDTH-1:0]  padr;
  } bank_rsp_t;

  // result of one virtual read with padr as bank joined with row
  typedef struct packed {
    logic                  vld;
    logic [DATA_WIDTH-1:0] data;
    logic                  fwrd;
    logic                  serr;
    logic                  derr;
    logic [PADR_WIDTH-1:0] padr;
  } rd_rsp_t;

endpackage

`default_nettype wire

//--- rtl/init_sweep.sv
`default_nettype none

module init_sweep (
  input  logic                               clk,
  input  logic                               rst,
  output logic                               init_active,
  output logic [mem_core_pkg::ROW_WIDTH-1:0] init_row,
  output logic                               ready
);
  import mem_core_pkg::*;

  // one extra bit so the counter can park at NUM_ROWS
  localparam int CNT_WIDTH = ROW_WIDTH + 1;

  logic [CNT_WIDTH-1:0] row_cnt;
  logic                 last_row;

  assign init_active = (row_cnt != CNT_WIDTH'(NUM_ROWS));
  assign init_row    = row_cnt[ROW_WIDTH-1:0];
  assign last_row    = (row_cnt == CNT_WIDTH'(NUM_ROWS - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      row_cnt <= '0;
    end else if (init_active) begin
      row_cnt <= row_cnt + 1'b1;
    end
  end

  // ready follows the last zero-fill write by one cycle and then holds
  always_ff @(posedge clk) begin
    if (rst) begin
      ready <= 1'b0;
    end else if (last_row) begin
      ready <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- rtl/addr_decode.sv
`default_nettype none

module addr_decode (
  input  logic [mem_core_pkg::ADDR_WIDTH-1:0] vaddr,
  output mem_core_pkg::bank_loc_t             loc,
  output logic                                in_range
);
  import mem_core_pkg::*;

  logic [ADDR_WIDTH-1:0] quot;
  logic [ADDR_WIDTH-1:0] rem;

  // bank count is not a power of two, so bank and row come from a real divide
  // consecutive addresses land in consecutive banks
  assign quot = vaddr / ADDR_WIDTH'(NUM_BANKS);
  assign rem  = vaddr % ADDR_WIDTH'(NUM_BANKS);

  always_comb begin
    loc.bank = rem[BANK_WIDTH-1:0];
    loc.row  = quot[ROW_WIDTH-1:0];
  end

  // upper addresses decode to rows past the end and must be dropped by the user
  assign in_range = (vaddr < ADDR_WIDTH'(NUM_ADDR));

endmodule

`default_nettype wire

//--- rtl/bank_request.sv
`default_nettype none

module bank_request (
  input  logic                                init_active,
  input  logic [mem_core_pkg::ROW_WIDTH-1:0]  init_row,
  input  mem_core_pkg::bank_loc_t             wr_loc,
  input  logic                                wr_in_range,
  input  logic                                vwrite,
  input  logic [mem_core_pkg::DATA_WIDTH-1:0] vdin,
  input  mem_core_pkg::rd_req_t               rd_acc [mem_core_pkg::NUM_RD_PORTS],
  output mem_core_pkg::wr_req_t               wr_acc,
  output mem_core_pkg::phys_wr_t              pwr [mem_core_pkg::NUM_PHYS],
  output mem_core_pkg::phys_rd_t              prd [mem_core_pkg::NUM_PHYS]
);
  import mem_core_pkg::*;

  // writes are ignored while the sweep owns the banks or when out of range
  always_comb begin
    wr_acc.vld  = vwrite & wr_in_range & ~init_active;
    wr_acc.loc  = wr_loc;
    wr_acc.data = vdin;
  end

  always_comb begin
    for (int i = 0; i < NUM_PHYS; i++) begin
      pwr[i] = '0;
      prd[i] = '0;
    end

    if (init_active) begin
      // zero-fill the same row in every copy
      for (int i = 0; i < NUM_PHYS; i++) begin
        pwr[i].en   = 1'b1;
        pwr[i].row  = init_row;
        pwr[i].data = '0;
      end
    end else begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        for (int p = 0; p < NUM_RD_PORTS; p++) begin
          // a write updates every port copy of its bank
          if (wr_acc.vld && (wr_acc.loc.bank == BANK_WIDTH'(b))) begin
            pwr[b * NUM_RD_PORTS + p].en   = 1'b1;
            pwr[b * NUM_RD_PORTS + p].row  = wr_acc.loc.row;
            pwr[b * NUM_RD_PORTS + p].data = wr_acc.data;
          end
          // each port reads only its own copy
          if (rd_acc[p].vld && (rd_acc[p].loc.bank == BANK_WIDTH'(b))) begin
            prd[b * NUM_RD_PORTS + p].en  = 1'b1;
            prd[b * NUM_RD_PORTS + p].row = rd_acc[p].loc.row;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- read_pipe/read_fwd_pipe.sv
`default_nettype none

module read_fwd_pipe #(
  parameter int SRAM_DELAY = 2
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  init_active,
  input  logic [mem_core_pkg::NUM_RD_PORTS-1:0] vread,
  input  mem_core_pkg::bank_loc_t               rd_loc [mem_core_pkg::NUM_RD_PORTS],
  input  mem_core_pkg::wr_req_t                 wr_acc,
  output mem_core_pkg::rd_req_t                 rd_acc [mem_core_pkg::NUM_RD_PORTS],
  output mem_core_pkg::rd_rsp_t                 stage_out [mem_core_pkg::NUM_RD_PORTS]
);
  import mem_core_pkg::*;

  // one shift register per port, as deep as the SRAM latency
  rd_rsp_t stg [NUM_RD_PORTS][SRAM_DELAY];

  for (genvar p = 0; p < NUM_RD_PORTS; p++) begin : g_port
    // reads are held off until the zero-fill is over
    always_comb begin
      rd_acc[p].vld = vread[p] & ~init_active;
      rd_acc[p].loc = rd_loc[p];
    end

    for (genvar s = 0; s < SRAM_DELAY; s++) begin : g_stage
      rd_rsp_t prev;
      rd_rsp_t upd;

      if (s == 0) begin : g_head
        always_comb begin
          prev      = '0;
          prev.vld  = rd_acc[p].vld;
          prev.padr = rd_acc[p].loc;
        end
      end else begin : g_tail
        assign prev = stg[p][s-1];
      end

      // a write to the same location while the read is in flight
      // overrides the stale SRAM word, later stages see the latest write
      always_comb begin
        upd = prev;
        if (wr_acc.vld && (wr_acc.loc == prev.padr)) begin
          upd.data = wr_acc.data;
          upd.fwrd = 1'b1;
        end
      end

      always_ff @(posedge clk) begin
        stg[p][s] <= upd;
        if (rst) begin
          stg[p][s].vld <= 1'b0;
        end
      end
    end

    assign stage_out[p] = stg[p][SRAM_DELAY-1];
  end

endmodule

`default_nettype wire

//--- read_pipe/read_return_mux.sv
`default_nettype none

module read_return_mux (
  input  mem_core_pkg::rd_rsp_t   stage_out [mem_core_pkg::NUM_RD_PORTS],
  input  mem_core_pkg::bank_rsp_t pdout [mem_core_pkg::NUM_PHYS],
  output mem_core_pkg::rd_rsp_t   vrd_rsp [mem_core_pkg::NUM_RD_PORTS]
);
  import mem_core_pkg::*;

  always_comb begin
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      bank_loc_t loc;
      bank_rsp_t sel;

      loc = stage_out[p].padr;

      // pick this port's copy of the bank the read went to
      sel = '0;
      for (int b = 0; b < NUM_BANKS; b++) begin
        if (loc.bank == BANK_WIDTH'(b)) begin
          sel = pdout[b * NUM_RD_PORTS + p];
        end
      end

      vrd_rsp[p].vld  = stage_out[p].vld;
      vrd_rsp[p].data = stage_out[p].fwrd ? stage_out[p].data : sel.data;
      vrd_rsp[p].fwrd = stage_out[p].fwrd | sel.fwrd;
      vrd_rsp[p].serr = sel.serr;
      vrd_rsp[p].derr = sel.derr;
      // the SRAM reports the row, the bank comes from the pipe
      vrd_rsp[p].padr = {loc.bank, sel.padr};
    end
  end

endmodule

`default_nettype wire

//--- rtl/mem_core_top.sv
`default_nettype none

module mem_core_top #(
  parameter int SRAM_DELAY = 2
) (
  input  logic                                  clk,
  input  logic                                  rst,

  // virtual write port
  input  logic                                  vwrite,
  input  logic [mem_core_pkg::ADDR_WIDTH-1:0]   vwr_addr,
  input  logic [mem_core_pkg::DATA_WIDTH-1:0]   vdin,

  // virtual read ports
  input  logic [mem_core_pkg::NUM_RD_PORTS-1:0] vread,
  input  logic [mem_core_pkg::ADDR_WIDTH-1:0]   vrd_addr [mem_core_pkg::NUM_RD_PORTS],
  output mem_core_pkg::rd_rsp_t                 vrd_rsp [mem_core_pkg::NUM_RD_PORTS],

  // physical SRAM side
  output mem_core_pkg::phys_wr_t                pwr [mem_core_pkg::NUM_PHYS],
  output mem_core_pkg::phys_rd_t                prd [mem_core_pkg::NUM_PHYS],
  input  mem_core_pkg::bank_rsp_t               pdout [mem_core_pkg::NUM_PHYS],

  output logic                                  ready
);
  import mem_core_pkg::*;

  logic                 init_active;
  logic [ROW_WIDTH-1:0] init_row;
  bank_loc_t            wr_loc;
  logic                 wr_in_range;
  bank_loc_t            rd_loc [NUM_RD_PORTS];
  wr_req_t              wr_acc;
  rd_req_t              rd_acc [NUM_RD_PORTS];
  rd_rsp_t              stage_out [NUM_RD_PORTS];

  init_sweep i_init_sweep (
    .clk         (clk),
    .rst         (rst),
    .init_active (init_active),
    .init_row    (init_row),
    .ready       (ready)
  );

  addr_decode i_wr_decode (
    .vaddr    (vwr_addr),
    .loc      (wr_loc),
    .in_range (wr_in_range)
  );

  // out-of-range reads just return whatever row they alias to
  for (genvar p = 0; p < NUM_RD_PORTS; p++) begin : g_rd_decode
    addr_decode i_rd_decode (
      .vaddr    (vrd_addr[p]),
      .loc      (rd_loc[p]),
      .in_range ()
    );
  end

  bank_request i_bank_request (
    .init_active (init_active),
    .init_row    (init_row),
    .wr_loc      (wr_loc),
    .wr_in_range (wr_in_range),
    .vwrite      (vwrite),
    .vdin        (vdin),
    .rd_acc      (rd_acc),
    .wr_acc      (wr_acc),
    .pwr         (pwr),
    .prd         (prd)
  );

  read_fwd_pipe #(
    .SRAM_DELAY (SRAM_DELAY)
  ) i_read_fwd_pipe (
    .clk         (clk),
    .rst         (rst),
    .init_active (init_active),
    .vread       (vread),
    .rd_loc      (rd_loc),
    .wr_acc      (wr_acc),
    .rd_acc      (rd_acc),
    .stage_out   (stage_out)
  );

  read_return_mux i_read_return_mux (
    .stage_out (stage_out),
    .pdout     (pdout),
    .vrd_rsp   (vrd_rsp)
  );

endmodule

`default_nettype wire

//--- tb/sram_bank_model.sv
`default_nettype none

module sram_bank_model #(
  parameter int SRAM_DELAY = 2,
  parameter int BANK       = 0
) (
  input  logic                    clk,
  input  mem_core_pkg::phys_wr_t  wr,
  input  mem_core_pkg::phys_rd_t  rd,
  output mem_core_pkg::bank_rsp_t rsp
);
  import mem_core_pkg::*;

  logic [DATA_WIDTH-1:0] mem [NUM_ROWS];
  bank_rsp_t             pipe [SRAM_DELAY];
  bank_rsp_t             rd_word;

  // nonzero start contents, unique per bank and row, so the zero-fill shows
  initial begin
    for (int r = 0; r < NUM_ROWS; r++) begin
      mem[r] = 32'hbad0_0000 | 32'(BANK * NUM_ROWS + r);
    end
  end

  // serr on odd rows of odd banks, derr on the top row only
  always_comb begin
    rd_word      = '0;
    rd_word.data = mem[rd.row];
    rd_word.serr = rd.row[0] & BANK[0];
    rd_word.derr = (rd.row == ROW_WIDTH'(NUM_ROWS - 1));
    rd_word.padr = rd.row;
  end

  // a read on the same edge as a write to its row still sees the old word
  always @(posedge clk) begin
    if (wr.en) begin
      mem[wr.row] <= wr.data;
    end
    pipe[0] <= rd.en ? rd_word : '0;
    for (int k = 1; k < SRAM_DELAY; k++) begin
      pipe[k] <= pipe[k-1];
    end
  end

  assign rsp = pipe[SRAM_DELAY-1];

endmodule

`default_nettype wire

//--- tb/mem_core_props.sv
`default_nettype none

module mem_core_props #(
  parameter int SRAM_DELAY = 2
) (
  input logic                   clk,
  input logic                   rst,
  input logic                   ready,
  input logic                   init_active,
  input mem_core_pkg::rd_req_t  rd_acc [mem_core_pkg::NUM_RD_PORTS],
  input mem_core_pkg::rd_rsp_t  vrd_rsp [mem_core_pkg::NUM_RD_PORTS],
  input mem_core_pkg::phys_rd_t prd [mem_core_pkg::NUM_PHYS]
);
  import mem_core_pkg::*;

  logic [NUM_PHYS-1:0] prd_en;

  always_comb begin
    for (int i = 0; i < NUM_PHYS; i++) begin
      prd_en[i] = prd[i].en;
    end
  end

  for (genvar p = 0; p < NUM_RD_PORTS; p++) begin : g_port
    // result strobe is the accepted read delayed by the SRAM latency
    a_vld_latency: assert property (@(posedge clk) disable iff (rst)
      vrd_rsp[p].vld == $past(rd_acc[p].vld, SRAM_DELAY))
      else $error("port %0d result strobe does not follow its read", p);

    a_vld_ready: assert property (@(posedge clk) disable iff (rst)
      vrd_rsp[p].vld |-> ready)
      else $error("port %0d result while not ready", p);
  end

  // the sweep owns the banks
  a_no_read_in_sweep: assert property (@(posedge clk) disable iff (rst)
    init_active |-> (prd_en == '0))
    else $error("physical read enabled during the sweep");

endmodule

bind mem_core_top mem_core_props #(
  .SRAM_DELAY (SRAM_DELAY)
) i_props (
  .clk         (clk),
  .rst         (rst),
  .ready       (ready),
  .init_active (init_active),
  .rd_acc      (rd_acc),
  .vrd_rsp     (vrd_rsp),
  .prd         (prd)
);

`default_nettype wire

//--- tb/mem_core_tb.sv
`default_nettype none

module mem_core_tb;
  import mem_core_pkg::*;

  localparam int SRAM_DELAY    = 2;
  localparam int READY_TIMEOUT = 200;
  localparam int DRAIN_TIMEOUT = 20;

  // one table row holds the write, both reads and the expected fwrd per port
  typedef struct packed {
    logic                    wr;
    logic [ADDR_WIDTH-1:0]   wa;
    logic [NUM_RD_PORTS-1:0] rd;
    logic [ADDR_WIDTH-1:0]   ra0;
    logic [ADDR_WIDTH-1:0]   ra1;
    logic [NUM_RD_PORTS-1:0] fw;
  } step_t;

  typedef struct packed {
    int   addr;
    int   cyc;
    logic fwrd;
  } pending_t;

  logic                    clk = 1'b0;
  logic                    rst;
  logic                    vwrite;
  logic [ADDR_WIDTH-1:0]   vwr_addr;
  logic [DATA_WIDTH-1:0]   vdin;
  logic [NUM_RD_PORTS-1:0] vread;
  logic [ADDR_WIDTH-1:0]   vrd_addr [NUM_RD_PORTS];
  rd_rsp_t                 vrd_rsp [NUM_RD_PORTS];
  phys_wr_t                pwr [NUM_PHYS];
  phys_rd_t                prd [NUM_PHYS];
  bank_rsp_t               pdout [NUM_PHYS];
  logic                    ready;

  step_t                 steps [$];
  pending_t              expq [NUM_RD_PORTS][$];
  logic [DATA_WIDTH-1:0] shadow [NUM_ADDR];
  logic                  pend_vld = 1'b0;
  int                    pend_addr;
  logic [DATA_WIDTH-1:0] pend_data;
  int                    cyc = 0;
  int                    val_errs = 0;
  int                    seq_errs = 0;

  mem_core_top #(
    .SRAM_DELAY (SRAM_DELAY)
  ) i_dut (
    .clk      (clk),
    .rst      (rst),
    .vwrite   (vwrite),
    .vwr_addr (vwr_addr),
    .vdin     (vdin),
    .vread    (vread),
    .vrd_addr (vrd_addr),
    .vrd_rsp  (vrd_rsp),
    .pwr      (pwr),
    .prd      (prd),
    .pdout    (pdout),
    .ready    (ready)
  );

  for (genvar i = 0; i < NUM_PHYS; i++) begin : g_bank
    sram_bank_model #(
      .SRAM_DELAY (SRAM_DELAY),
      .BANK       (i / NUM_RD_PORTS)
    ) i_bank (
      .clk (clk),
      .wr  (pwr[i]),
      .rd  (prd[i]),
      .rsp (pdout[i])
    );
  end

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  function automatic step_t make_step(logic wr, int wa, logic [NUM_RD_PORTS-1:0] rd,
                                      int ra0, int ra1, logic [NUM_RD_PORTS-1:0] fw);
    step_t s;
    s.wr  = wr;
    s.wa  = ADDR_WIDTH'(wa);
    s.rd  = rd;
    s.ra0 = ADDR_WIDTH'(ra0);
    s.ra1 = ADDR_WIDTH'(ra1);
    s.fw  = fw;
    return s;
  endfunction

  task automatic load_steps();
    // fresh memory reads zero, then plain write and read back
    steps.push_back(make_step(1'b0, 0, 2'b11, 0, 383, 2'b00));
    steps.push_back(make_step(1'b0, 0, 2'b11, 22, 23, 2'b00));
    steps.push_back(make_step(1'b1, 10, 2'b00, 0, 0, 2'b00));
    steps.push_back(make_step(1'b1, 383, 2'b00, 0, 0, 2'b00));
    steps.push_back(make_step(1'b0, 0, 2'b11, 10, 10, 2'b00));
    steps.push_back(make_step(1'b0, 0, 2'b11, 383, 11, 2'b00));
    // forwarding in the read cycle, one cycle later, and two writes in the window
    steps.push_back(make_step(1'b1, 50, 2'b01, 50, 0, 2'b01));
    steps.push_back(make_step(1'b0, 0, 2'b10, 0, 60, 2'b10));
    steps.push_back(make_step(1'b1, 60, 2'b00, 0, 0, 2'b00));
    steps.push_back(make_step(1'b1, 70, 2'b11, 70, 70, 2'b11));
    steps.push_back(make_step(1'b1, 70, 2'b00, 0, 0, 2'b00));
    // write just before a read, and one just after the window
    steps.push_back(make_step(1'b1, 80, 2'b00, 0, 0, 2'b00));
    steps.push_back(make_step(1'b0, 0, 2'b11, 80, 90, 2'b00));
    steps.push_back(make_step(1'b0, 0, 2'b00, 0, 0, 2'b00));
    steps.push_back(make_step(1'b1, 90, 2'b00, 0, 0, 2'b00));
    // error flags
    steps.push_back(make_step(1'b0, 0, 2'b11, 7, 379, 2'b00));
    steps.push_back(make_step(1'b0, 0, 2'b11, 378, 7, 2'b00));
    // out-of-range writes alias to 0, 6 and 127
    steps.push_back(make_step(1'b1, 384, 2'b00, 0, 0, 2'b00));
    steps.push_back(make_step(1'b1, 390, 2'b01, 6, 0, 2'b00));
    steps.push_back(make_step(1'b1, 511, 2'b11, 0, 127, 2'b00));
    steps.push_back(make_step(1'b1, 201, 2'b11, 20, 201, 2'b10));
    steps.push_back(make_step(1'b1, 10, 2'b11, 10, 90, 2'b01));
  endtask

  // move to the next drive point and put the write the DUT just took into the shadow
  task automatic next_cycle();
    @(posedge clk);
    #2;
    if (pend_vld) begin
      shadow[pend_addr] = pend_data;
    end
    pend_vld = 1'b0;
  endtask

  task automatic apply_step(step_t s);
    vwrite      = s.wr;
    vwr_addr    = s.wa;
    vdin        = $urandom();
    vread       = s.rd;
    vrd_addr[0] = s.ra0;
    vrd_addr[1] = s.ra1;
    if (s.wr && int'(s.wa) < NUM_ADDR) begin
      pend_vld  = 1'b1;
      pend_addr = int'(s.wa);
      pend_data = vdin;
    end
    if (s.rd[0]) begin
      expq[0].push_back(pending_t'{int'(s.ra0), cyc, s.fw[0]});
    end
    if (s.rd[1]) begin
      expq[1].push_back(pending_t'{int'(s.ra1), cyc, s.fw[1]});
    end
  endtask

  task automatic check_port(int p);
    rd_rsp_t               rsp;
    pending_t              e;
    int                    bank;
    int                    row;
    logic [DATA_WIDTH-1:0] exp_data;
    logic [PADR_WIDTH-1:0] exp_padr;
    logic                  exp_serr;
    logic                  exp_derr;
    rsp = vrd_rsp[p];
    if (!rsp.vld) begin
      if (expq[p].size() > 0 && cyc - expq[p][0].cyc >= SRAM_DELAY) begin
        $display("port %0d: read from cycle %0d gave no result", p, expq[p][0].cyc);
        seq_errs++;
        void'(expq[p].pop_front());
      end
    end else if (expq[p].size() == 0) begin
      $display("port %0d: result at time %0t without a pending read", p, $time);
      seq_errs++;
    end else begin
      e        = expq[p].pop_front();
      bank     = e.addr % NUM_BANKS;
      row      = e.addr / NUM_BANKS;
      exp_data = shadow[e.addr];
      exp_padr = {BANK_WIDTH'(bank), ROW_WIDTH'(row)};
      exp_serr = row[0] & bank[0];
      exp_derr = (row == NUM_ROWS - 1);
      if (cyc - e.cyc != SRAM_DELAY) begin
        $display("FAILED %0t: port %0d addr %0d latency %0d", $time, p, e.addr, cyc - e.cyc);
        val_errs++;
      end
      if (rsp.data !== exp_data) begin
        $display("FAILED %0t: port %0d addr %0d data %h expected %h",
                 $time, p, e.addr, rsp.data, exp_data);
        val_errs++;
      end
      if (rsp.fwrd !== e.fwrd || rsp.serr !== exp_serr || rsp.derr !== exp_derr) begin
        $display("FAILED %0t: port %0d addr %0d fwrd/serr/derr %b%b%b expected %b%b%b",
                 $time, p, e.addr, rsp.fwrd, rsp.serr, rsp.derr, e.fwrd, exp_serr, exp_derr);
        val_errs++;
      end
      if (rsp.padr !== exp_padr) begin
        $display("FAILED %0t: port %0d addr %0d padr %h expected %h",
                 $time, p, e.addr, rsp.padr, exp_padr);
        val_errs++;
      end
    end
  endtask

  always @(negedge clk) begin
    if (!rst) begin
      for (int p = 0; p < NUM_RD_PORTS; p++) begin
        check_port(p);
      end
    end
  end

  initial begin
    int n;
    void'($urandom(32'h6c19_72a7));
    rst      = 1'b1;
    vwrite   = 1'b0;
    vwr_addr = '0;
    vdin     = '0;
    vread    = '0;
    foreach (vrd_addr[i]) begin
      vrd_addr[i] = '0;
    end
    foreach (shadow[i]) begin
      shadow[i] = '0;
    end
    load_steps();
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;

    // traffic during the sweep must be dropped
    n = 0;
    while (!ready && n < READY_TIMEOUT) begin
      vwrite      = 1'b1;
      vwr_addr    = ADDR_WIDTH'(20 + n % 4);
      vdin        = $urandom();
      vread       = '1;
      vrd_addr[0] = ADDR_WIDTH'(20 + n % 4);
      vrd_addr[1] = ADDR_WIDTH'(23 - n % 4);
      next_cycle();
      n++;
    end

    if (!ready) begin
      $display("timeout: ready did not rise within %0d cycles", READY_TIMEOUT);
      seq_errs++;
    end else begin
      // one zero-fill write per row, ready in the cycle after the last one
      if (n != NUM_ROWS) begin
        $display("FAILED %0t: ready rose after %0d cycles expected %0d", $time, n, NUM_ROWS);
        val_errs++;
      end
      foreach (steps[i]) begin
        apply_step(steps[i]);
        next_cycle();
      end
      apply_step(make_step(1'b0, 0, 2'b00, 0, 0, 2'b00));
      n = 0;
      while (expq[0].size() + expq[1].size() > 0 && n < DRAIN_TIMEOUT) begin
        next_cycle();
        n++;
      end
      if (expq[0].size() + expq[1].size() > 0) begin
        $display("timeout: %0d reads never returned", expq[0].size() + expq[1].size());
        seq_errs++;
      end
    end

    $display("errors: %0d value, %0d protocol", val_errs, seq_errs);
    if (val_errs + seq_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
common/mem_core_pkg.sv
rtl/init_sweep.sv
rtl/addr_decode.sv
rtl/bank_request.sv
read_pipe/read_fwd_pipe.sv
read_pipe/read_return_mux.sv
rtl/mem_core_top.sv
tb/sram_bank_model.sv
tb/mem_core_props.sv
tb/mem_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and take the verdict from the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert -f src.f --top-module mem_core_tb -Mdir "$BUILD_DIR" -o mem_core_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$BUILD_DIR/mem_core_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
exit 0
